/* rtl/armPkg.sv */
`default_nettype none

package armPkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  regAddr_t;
  typedef logic [3:0]  flags_t;
  typedef logic [3:0]  aluOp_t;
  typedef logic [1:0]  shiftType_t;
  typedef logic [3:0]  cond_t;
  typedef logic [1:0]  fwdSel_t;

  localparam word_t PC_STEP  = 32'd4;
  localparam int    NUM_REGS = 15;

  // Instruction bit positions
  localparam int I_BIT = 25;
  localparam int S_BIT = 20;
  localparam int L_BIT = 20;

  // Bit positions inside NZCV
  localparam int FLAG_N = 3;
  localparam int FLAG_Z = 2;
  localparam int FLAG_C = 1;
  localparam int FLAG_V = 0;

  localparam aluOp_t OP_AND = 4'b0000;
  localparam aluOp_t OP_EOR = 4'b0001;
  localparam aluOp_t OP_SUB = 4'b0010;
  localparam aluOp_t OP_ADD = 4'b0100;
  localparam aluOp_t OP_CMP = 4'b1010;
  localparam aluOp_t OP_ORR = 4'b1100;
  localparam aluOp_t OP_MOV = 4'b1101;

  localparam shiftType_t SH_LSL = 2'b00;
  localparam shiftType_t SH_LSR = 2'b01;
  localparam shiftType_t SH_ASR = 2'b10;
  localparam shiftType_t SH_ROR = 2'b11;

  localparam cond_t COND_EQ = 4'h0;
  localparam cond_t COND_NE = 4'h1;
  localparam cond_t COND_CS = 4'h2;
  localparam cond_t COND_CC = 4'h3;
  localparam cond_t COND_MI = 4'h4;
  localparam cond_t COND_PL = 4'h5;
  localparam cond_t COND_VS = 4'h6;
  localparam cond_t COND_VC = 4'h7;
  localparam cond_t COND_HI = 4'h8;
  localparam cond_t COND_LS = 4'h9;
  localparam cond_t COND_GE = 4'ha;
  localparam cond_t COND_LT = 4'hb;
  localparam cond_t COND_GT = 4'hc;
  localparam cond_t COND_LE = 4'hd;
  localparam cond_t COND_AL = 4'he;

  localparam fwdSel_t FWD_REG = 2'd0;
  localparam fwdSel_t FWD_WB  = 2'd1;
  localparam fwdSel_t FWD_MEM = 2'd2;

  // Decode to execute
  typedef struct packed {
    cond_t      cond;
    aluOp_t     aluOp;
    logic       setFlags;
    logic       useImm;
    shiftType_t shiftType;
    logic [4:0] shiftAmt;
    logic       isLoad;
    logic       isStore;
    logic       isBranch;
    logic       regWe;
    regAddr_t   rn;
    regAddr_t   rm;
    regAddr_t   rd;
    word_t      rnVal;
    word_t      rmVal;
    word_t      rdVal;
    word_t      imm;
    word_t      pcPlus8;
    logic       valid;
  } decodedOp_t;

  // Execute to memory
  typedef struct packed {
    logic     valid;
    logic     isLoad;
    logic     isStore;
    logic     regWe;
    regAddr_t rd;
    word_t    aluResult;
    word_t    storeData;
  } memOp_t;

  typedef struct packed {
    logic     regWe;
    regAddr_t rd;
    word_t    value;
  } writeBack_t;

endpackage

`default_nettype wire

/* rtl/regFile.sv */
`timescale 1ns/10ps
`default_nettype none

module regFile import armPkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  regAddr_t   ra1,
  input  regAddr_t   ra2,
  input  regAddr_t   ra3,
  output word_t      rd1,
  output word_t      rd2,
  output word_t      rd3,
  input  writeBack_t wb
);

  word_t regs [NUM_REGS];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.regWe && wb.rd < NUM_REGS) begin
      regs[wb.rd] <= wb.value;
    end
  end

  // Writeback value bypasses the array, r15 reads as zero
  function automatic word_t readReg(regAddr_t ra);
    if (wb.regWe && wb.rd == ra) return wb.value;
    if (ra < NUM_REGS) return regs[ra];
    return '0;
  endfunction

  always_comb begin
    rd1 = readReg(ra1);
    rd2 = readReg(ra2);
    rd3 = readReg(ra3);
  end

  // PC is only changed by branches
  noPcWrite: assert property (@(posedge clk) disable iff (!rstN)
    wb.regWe |-> wb.rd != 4'd15)
    else $error("register file write to r15");

endmodule

`default_nettype wire

/* rtl/fetchDecode.sv */
`timescale 1ns/10ps
`default_nettype none

module fetchDecode import armPkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  logic       stallF,
  input  logic       stallD,
  input  logic       flushD,
  input  logic       branchTaken,
  input  word_t      branchTarget,
  output word_t      instrAddr,
  input  word_t      instr,
  output regAddr_t   ra1,
  output regAddr_t   ra2,
  output regAddr_t   ra3,
  input  word_t      rd1,
  input  word_t      rd2,
  input  word_t      rd3,
  output logic       usesRn,
  output logic       usesRm,
  output logic       usesRd,
  output decodedOp_t dOp
);

  word_t  pcF;
  word_t  pcPlus4F;
  word_t  instrD;
  logic   validD;
  logic   isDp;
  logic   isMem;
  logic   isBr;
  aluOp_t opD;
  word_t  imm8;
  word_t  rotImm;
  word_t  brOff;

  assign pcPlus4F  = pcF + PC_STEP;
  assign instrAddr = pcF;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pcF <= '0;
    end else if (branchTaken) begin
      pcF <= branchTarget;
    end else if (!stallF) begin
      pcF <= pcPlus4F;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validD <= 1'b0;
    end else if (flushD) begin
      validD <= 1'b0;
    end else if (!stallD) begin
      validD <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!stallD) begin
      instrD <= instr;
    end
  end

  // Instruction class from bits 27:25
  assign isDp  = instrD[27:26] == 2'b00;
  assign isMem = instrD[27:26] == 2'b01;
  assign isBr  = instrD[27:25] == 3'b101;
  assign opD   = isMem ? OP_ADD : instrD[24:21];

  // 8-bit immediate rotated right by twice the rotate field
  assign imm8   = {24'b0, instrD[7:0]};
  assign rotImm = 32'({imm8, imm8} >> {instrD[11:8], 1'b0});
  assign brOff  = {{6{instrD[23]}}, instrD[23:0], 2'b00};

  assign ra1 = instrD[19:16];
  assign ra2 = instrD[3:0];
  assign ra3 = instrD[15:12];

  // Only real source reads may cause a load-use stall
  assign usesRn = validD & ((isDp & opD != OP_MOV) | isMem);
  assign usesRm = validD & isDp & ~instrD[I_BIT];
  assign usesRd = validD & isMem & ~instrD[L_BIT];

  always_comb begin
    dOp.cond      = instrD[31:28];
    dOp.aluOp     = opD;
    dOp.setFlags  = isDp & (instrD[S_BIT] | opD == OP_CMP);
    dOp.useImm    = isMem | instrD[I_BIT];
    dOp.shiftType = instrD[6:5];
    dOp.shiftAmt  = instrD[11:7];
    dOp.isLoad    = isMem & instrD[L_BIT];
    dOp.isStore   = isMem & ~instrD[L_BIT];
    dOp.isBranch  = isBr;
    dOp.regWe     = (isDp & opD != OP_CMP) | (isMem & instrD[L_BIT]);
    dOp.rn        = ra1;
    dOp.rm        = ra2;
    dOp.rd        = ra3;
    dOp.rnVal     = rd1;
    dOp.rmVal     = rd2;
    dOp.rdVal     = rd3;
    dOp.imm       = isBr ? brOff : (isMem ? {20'b0, instrD[11:0]} : rotImm);
    // PC already runs one word ahead of decode
    dOp.pcPlus8   = pcPlus4F;
    dOp.valid     = validD;
  end

endmodule

`default_nettype wire

/* rtl/execUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module execUnit import armPkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  logic       flushE,
  input  fwdSel_t    fwdA,
  input  fwdSel_t    fwdB,
  input  fwdSel_t    fwdD,
  input  decodedOp_t dOp,
  input  word_t      memResult,
  input  writeBack_t wb,
  output memOp_t     eOp,
  output logic       branchTaken,
  output word_t      branchTarget,
  output regAddr_t   exRn,
  output regAddr_t   exRm,
  output regAddr_t   exRd,
  output regAddr_t   exDest,
  output logic       exIsLoad
);

  decodedOp_t ex;
  flags_t     flagsQ;
  flags_t     aluFlags;
  word_t      srcA, srcM, srcD, shOut, op2, res;
  logic       shCarry, c, v, pass;
  logic [32:0] sum;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ex <= '0;
    end else if (flushE) begin
      ex <= '0;
    end else begin
      ex <= dOp;
    end
  end

  function automatic word_t pickOperand(fwdSel_t sel, word_t regVal, word_t memVal,
                                        word_t wbVal);
    if (sel == FWD_MEM) return memVal;
    if (sel == FWD_WB) return wbVal;
    return regVal;
  endfunction

  function automatic logic condPass(cond_t cond, flags_t f);
    case (cond)
      COND_EQ: return f[FLAG_Z];
      COND_NE: return !f[FLAG_Z];
      COND_CS: return f[FLAG_C];
      COND_CC: return !f[FLAG_C];
      COND_MI: return f[FLAG_N];
      COND_PL: return !f[FLAG_N];
      COND_VS: return f[FLAG_V];
      COND_VC: return !f[FLAG_V];
      COND_HI: return f[FLAG_C] && !f[FLAG_Z];
      COND_LS: return !f[FLAG_C] || f[FLAG_Z];
      COND_GE: return f[FLAG_N] == f[FLAG_V];
      COND_LT: return f[FLAG_N] != f[FLAG_V];
      COND_GT: return !f[FLAG_Z] && f[FLAG_N] == f[FLAG_V];
      COND_LE: return f[FLAG_Z] || f[FLAG_N] != f[FLAG_V];
      COND_AL: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  assign srcA = pickOperand(fwdA, ex.rnVal, memResult, wb.value);
  assign srcM = pickOperand(fwdB, ex.rmVal, memResult, wb.value);
  assign srcD = pickOperand(fwdD, ex.rdVal, memResult, wb.value);

  // Barrel shifter with the special encodings for amount zero
  always_comb begin
    shOut   = srcM;
    shCarry = flagsQ[FLAG_C];
    case (ex.shiftType)
      SH_LSL: if (ex.shiftAmt != 0) {shCarry, shOut} = {1'b0, srcM} << ex.shiftAmt;
      SH_LSR: begin
        if (ex.shiftAmt == 0) {shCarry, shOut} = {srcM[31], 32'b0};
        else {shOut, shCarry} = {srcM, 1'b0} >> ex.shiftAmt;
      end
      SH_ASR: begin
        if (ex.shiftAmt == 0) {shCarry, shOut} = {33{srcM[31]}};
        else {shOut, shCarry} = $signed({srcM, 1'b0}) >>> ex.shiftAmt;
      end
      default: begin
        // ROR #0 is RRX
        if (ex.shiftAmt == 0) begin
          {shOut, shCarry} = {flagsQ[FLAG_C], srcM};
        end else begin
          shOut   = (srcM >> ex.shiftAmt) | (srcM << (6'd32 - {1'b0, ex.shiftAmt}));
          shCarry = shOut[31];
        end
      end
    endcase
  end

  assign op2 = ex.useImm ? ex.imm : shOut;

  always_comb begin
    sum = '0;
    res = op2;
    c   = ex.useImm ? flagsQ[FLAG_C] : shCarry;
    v   = flagsQ[FLAG_V];
    case (ex.aluOp)
      OP_AND: res = srcA & op2;
      OP_EOR: res = srcA ^ op2;
      OP_ORR: res = srcA | op2;
      OP_SUB, OP_CMP: begin
        sum = {1'b0, srcA} + {1'b0, ~op2} + 33'd1;
        {c, res} = sum;
        v = (srcA[31] != op2[31]) && (res[31] != srcA[31]);
      end
      OP_ADD: begin
        sum = {1'b0, srcA} + {1'b0, op2};
        {c, res} = sum;
        v = (srcA[31] == op2[31]) && (res[31] != srcA[31]);
      end
      default: res = op2;
    endcase
    aluFlags = {res[31], res == '0, c, v};
  end

  assign pass = condPass(ex.cond, flagsQ);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flagsQ <= '0;
    end else if (ex.valid && pass && ex.setFlags) begin
      flagsQ <= aluFlags;
    end
  end

  always_comb begin
    eOp.valid     = ex.valid;
    eOp.isLoad    = ex.valid & ex.isLoad & pass;
    eOp.isStore   = ex.valid & ex.isStore & pass;
    eOp.regWe     = ex.valid & ex.regWe & pass;
    eOp.rd        = ex.rd;
    eOp.aluResult = res;
    eOp.storeData = srcD;
  end

  assign branchTaken  = ex.valid & ex.isBranch & pass;
  assign branchTarget = ex.pcPlus8 + ex.imm;

  assign exRn     = ex.rn;
  assign exRm     = ex.rm;
  assign exRd     = ex.rd;
  assign exDest   = ex.rd;
  assign exIsLoad = ex.valid & ex.isLoad;

  // Slot behind a taken branch must come up empty
  branchFlush: assert property (@(posedge clk) disable iff (!rstN)
    branchTaken |=> !ex.valid)
    else $error("instruction survived a taken branch");

endmodule

`default_nettype wire

/* rtl/resultStage.sv */
`timescale 1ns/10ps
`default_nettype none

module resultStage import armPkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  memOp_t     eOp,
  output word_t      dataAddr,
  output word_t      dataWdata,
  output logic       dataWe,
  input  word_t      dataRdata,
  output word_t      memResult,
  output regAddr_t   memDest,
  output logic       memRegWe,
  output writeBack_t wb
);

  memOp_t   memQ;
  logic     wbRegWe;
  logic     wbLoad;
  regAddr_t wbRd;
  word_t    wbAlu;
  word_t    wbData;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      memQ    <= '0;
      wbRegWe <= 1'b0;
      wbLoad  <= 1'b0;
    end else begin
      memQ    <= eOp;
      wbRegWe <= memQ.valid & memQ.regWe;
      wbLoad  <= memQ.valid & memQ.isLoad;
    end
  end

  // Writeback payload
  always_ff @(posedge clk) begin
    wbRd   <= memQ.rd;
    wbAlu  <= memQ.aluResult;
    wbData <= dataRdata;
  end

  assign dataAddr  = memQ.aluResult;
  assign dataWdata = memQ.storeData;
  assign dataWe    = memQ.valid & memQ.isStore;
  assign memResult = memQ.aluResult;
  assign memDest   = memQ.rd;
  assign memRegWe  = memQ.valid & memQ.regWe;

  always_comb begin
    wb.regWe = wbRegWe;
    wb.rd    = wbRd;
    wb.value = wbLoad ? wbData : wbAlu;
  end

  // A store never loads and never writes a register afterwards
  storeOnly: assert property (@(posedge clk) disable iff (!rstN)
    dataWe |-> !memQ.isLoad ##1 !wb.regWe)
    else $error("store mixed with a load or register write");

endmodule

`default_nettype wire

/* rtl/hazardUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module hazardUnit import armPkg::*; (
  input  regAddr_t   decRn,
  input  regAddr_t   decRm,
  input  regAddr_t   decRd,
  input  logic       decUsesRn,
  input  logic       decUsesRm,
  input  logic       decUsesRd,
  input  regAddr_t   exRn,
  input  regAddr_t   exRm,
  input  regAddr_t   exRd,
  input  regAddr_t   exDest,
  input  logic       exRegWe,
  input  logic       exIsLoad,
  input  regAddr_t   memDest,
  input  logic       memRegWe,
  input  writeBack_t wb,
  input  logic       branchTaken,
  output fwdSel_t    fwdA,
  output fwdSel_t    fwdB,
  output fwdSel_t    fwdD,
  output logic       stallF,
  output logic       stallD,
  output logic       flushD,
  output logic       flushE
);

  logic loadUse;

  // Memory stage holds the younger result, so it wins
  function automatic fwdSel_t pickFwd(regAddr_t src);
    if (memRegWe && memDest == src) return FWD_MEM;
    if (wb.regWe && wb.rd == src) return FWD_WB;
    return FWD_REG;
  endfunction

  always_comb begin
    fwdA = pickFwd(exRn);
    fwdB = pickFwd(exRm);
    fwdD = pickFwd(exRd);
  end

  // Load result exists only after the memory stage
  assign loadUse = exIsLoad & exRegWe &
                   ((decUsesRn & decRn == exDest) |
                    (decUsesRm & decRm == exDest) |
                    (decUsesRd & decRd == exDest));

  assign stallF = loadUse;
  assign stallD = loadUse;
  assign flushD = branchTaken;
  assign flushE = loadUse | branchTaken;

  // A branch in execute is never a load
  always_comb begin
    stallVsFlush: assert (!(stallD && flushD))
      else $error("decode stalled and flushed at once");
  end

endmodule

`default_nettype wire

/* rtl/armPipe.sv */
`timescale 1ns/10ps
`default_nettype none

module armPipe import armPkg::*; (
  input  logic  clk,
  input  logic  rstN,
  output word_t instrAddr,
  input  word_t instr,
  output word_t dataAddr,
  output word_t dataWdata,
  output logic  dataWe,
  input  word_t dataRdata
);

  decodedOp_t dOp;
  memOp_t     eOp;
  writeBack_t wb;
  regAddr_t   ra1, ra2, ra3;
  word_t      rd1, rd2, rd3;
  logic       usesRn, usesRm, usesRd;
  logic       branchTaken;
  word_t      branchTarget;
  regAddr_t   exRn, exRm, exRd, exDest;
  logic       exIsLoad;
  word_t      memResult;
  regAddr_t   memDest;
  logic       memRegWe;
  fwdSel_t    fwdA, fwdB, fwdD;
  logic       stallF, stallD, flushD, flushE;

  regFile regFile_i (
    .clk(clk), .rstN(rstN),
    .ra1(ra1), .ra2(ra2), .ra3(ra3),
    .rd1(rd1), .rd2(rd2), .rd3(rd3),
    .wb(wb)
  );

  fetchDecode fetchDecode_i (
    .clk(clk), .rstN(rstN),
    .stallF(stallF), .stallD(stallD), .flushD(flushD),
    .branchTaken(branchTaken), .branchTarget(branchTarget),
    .instrAddr(instrAddr), .instr(instr),
    .ra1(ra1), .ra2(ra2), .ra3(ra3),
    .rd1(rd1), .rd2(rd2), .rd3(rd3),
    .usesRn(usesRn), .usesRm(usesRm), .usesRd(usesRd),
    .dOp(dOp)
  );

  execUnit execUnit_i (
    .clk(clk), .rstN(rstN), .flushE(flushE),
    .fwdA(fwdA), .fwdB(fwdB), .fwdD(fwdD),
    .dOp(dOp), .memResult(memResult), .wb(wb), .eOp(eOp),
    .branchTaken(branchTaken), .branchTarget(branchTarget),
    .exRn(exRn), .exRm(exRm), .exRd(exRd), .exDest(exDest),
    .exIsLoad(exIsLoad)
  );

  resultStage resultStage_i (
    .clk(clk), .rstN(rstN), .eOp(eOp),
    .dataAddr(dataAddr), .dataWdata(dataWdata), .dataWe(dataWe),
    .dataRdata(dataRdata), .memResult(memResult),
    .memDest(memDest), .memRegWe(memRegWe), .wb(wb)
  );

  hazardUnit hazardUnit_i (
    .decRn(ra1), .decRm(ra2), .decRd(ra3),
    .decUsesRn(usesRn), .decUsesRm(usesRm), .decUsesRd(usesRd),
    .exRn(exRn), .exRm(exRm), .exRd(exRd), .exDest(exDest),
    .exRegWe(eOp.regWe), .exIsLoad(exIsLoad),
    .memDest(memDest), .memRegWe(memRegWe), .wb(wb),
    .branchTaken(branchTaken),
    .fwdA(fwdA), .fwdB(fwdB), .fwdD(fwdD),
    .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE)
  );

endmodule

`default_nettype wire

/* bench/clockGen.sv */
`timescale 1ns/10ps
`default_nettype none

module clockGen (
  output logic clk,
  output logic rstN
);

  localparam int HALF_NS = 50;
  localparam int RESET_CYCLES = 16;

  always #HALF_NS clk = ~clk;

  // Reset released on a falling edge, away from the sampling edge
  initial begin
    clk  = 1'b0;
    rstN = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
  end

endmodule

`default_nettype wire

/* bench/armPipeTb.sv */
`timescale 1ns/10ps
`default_nettype none

module armPipeTb import armPkg::*; ();

  localparam int IMEM_WORDS = 256;
  localparam int DMEM_WORDS = 256;
  localparam int PROG_LEN = 170;
  localparam int RESET_TIMEOUT = 100;
  localparam int STORE_TIMEOUT = 4000;
  localparam int DRAIN_CYCLES = 40;
  localparam logic [15:0] SEED = 16'd31189;

  logic  clk, rstN, dataWe, headValid, weSeen;
  word_t instrAddr, instr, dataAddr, dataWdata, dataRdata, headAddr, headData;
  word_t imem [IMEM_WORDS];
  word_t dmem [DMEM_WORDS];
  word_t modelMem [DMEM_WORDS];
  word_t modelReg [16];
  flags_t modelFlags;
  logic [15:0] lfsr;
  int progIdx, errors, storesSeen, expectedTotal;
  word_t expAddrQ[$];
  word_t expDataQ[$];
  aluOp_t dpOps [6] = '{OP_ADD, OP_SUB, OP_AND, OP_ORR, OP_EOR, OP_MOV};

  clockGen clockGen_i (.clk(clk), .rstN(rstN));

  armPipe armPipe_i (
    .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instr(instr),
    .dataAddr(dataAddr), .dataWdata(dataWdata), .dataWe(dataWe), .dataRdata(dataRdata)
  );

  // Both memories answer combinationally
  assign instr     = imem[instrAddr[9:2]];
  assign dataRdata = dmem[dataAddr[9:2]];

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic nextBit();
    logic b;
    b = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], b};
    return b;
  endfunction

  function automatic word_t randBits(int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], nextBit()};
    end
    return v;
  endfunction

  function automatic word_t fillWord(int i);
    return (32'h9e3779b9 * (i + 1)) ^ i;
  endfunction

  function automatic regAddr_t randDest();
    regAddr_t r;
    r = regAddr_t'(randBits(3));
    return (r == 0) ? 4'd1 : r;
  endfunction

  function automatic cond_t randCond();
    cond_t c;
    c = cond_t'(randBits(4));
    return (c == 4'hf) ? COND_AL : c;
  endfunction

  // Word-aligned offset below 256
  function automatic logic [11:0] wordOffset();
    return {4'b0, 6'(randBits(6)), 2'b00};
  endfunction

  // Immediate form or register shifted by 1 to 31
  function automatic logic [11:0] randOp2(logic isImm);
    logic [4:0] amt;
    if (isImm) return 12'(randBits(12));
    amt = 5'(randBits(5));
    if (amt == 0) amt = 5'd1;
    return {amt, 2'(randBits(2)), 2'b00, 3'(randBits(3))};
  endfunction

  function automatic word_t dpWord(cond_t c, aluOp_t op, logic isImm, logic s,
                                   regAddr_t rn, regAddr_t rd, logic [11:0] op2);
    return {c, 2'b00, isImm, op, s, rn, rd, op2};
  endfunction

  function automatic word_t memWord(logic load, regAddr_t rd, logic [11:0] off);
    return {COND_AL, 2'b01, 5'b01100, load, 4'd0, rd, off};
  endfunction

  function automatic word_t brWord(cond_t c, logic [23:0] off);
    return {c, 4'b1010, off};
  endfunction

  task automatic emit(word_t w);
    imem[progIdx] = w;
    progIdx++;
  endtask

  task automatic genProgram();
    word_t    kind;
    aluOp_t   op;
    regAddr_t rd, ra;
    logic     isImm;
    int       skip;
    progIdx = 0;
    while (progIdx < PROG_LEN) begin
      kind  = randBits(3);
      isImm = nextBit();
      rd    = randDest();
      case (kind)
        0, 1, 2: begin
          op = dpOps[randBits(3) % 6];
          ra = (op == OP_MOV) ? 4'd0 : regAddr_t'(randBits(3));
          emit(dpWord(COND_AL, op, isImm, 1'b0, ra, rd, randOp2(isImm)));
          if (nextBit()) emit(memWord(1'b0, rd, wordOffset()));
        end
        3: begin
          // Consumer sits right behind the load
          ra = randDest();
          emit(memWord(1'b1, ra, wordOffset()));
          if (nextBit()) begin
            emit(memWord(1'b0, ra, wordOffset()));
          end else begin
            emit(dpWord(COND_AL, OP_ADD, isImm, 1'b0, ra, rd, randOp2(isImm)));
            emit(memWord(1'b0, rd, wordOffset()));
          end
        end
        4: begin
          emit(dpWord(COND_AL, OP_CMP, isImm, 1'b1, regAddr_t'(randBits(3)), 4'd0,
                      randOp2(isImm)));
          op = dpOps[randBits(3) % 6];
          emit(dpWord(randCond(), op, isImm, 1'b0, randDest(), rd, randOp2(isImm)));
          emit(memWord(1'b0, rd, wordOffset()));
        end
        5, 6: begin
          skip = 1 + randBits(2) % 3;
          emit(brWord(randCond(), 24'(skip - 1)));
        end
        default: emit(memWord(1'b0, regAddr_t'(randBits(3)), wordOffset()));
      endcase
    end
    for (int i = 1; i < 8; i++) begin
      emit(memWord(1'b0, regAddr_t'(i), 12'(256 + 4 * i)));
    end
    emit(brWord(COND_AL, 24'hfffffe));
  endtask

  function automatic logic condHolds(cond_t c, flags_t f);
    logic n, z, cy, v, r;
    {n, z, cy, v} = f;
    case (c[3:1])
      3'd0: r = z;
      3'd1: r = cy;
      3'd2: r = n;
      3'd3: r = v;
      3'd4: r = cy & ~z;
      3'd5: r = (n == v);
      3'd6: r = ~z & (n == v);
      default: r = 1'b1;
    endcase
    return (c == COND_AL) ? 1'b1 : r ^ c[0];
  endfunction

  function automatic word_t operand2(word_t ins);
    word_t v, imm8;
    int r;
    imm8 = {24'b0, ins[7:0]};
    r = 2 * ins[11:8];
    v = modelReg[ins[3:0]];
    if (ins[25]) return (r == 0) ? imm8 : (imm8 >> r) | (imm8 << (32 - r));
    case (ins[6:5])
      SH_LSL: return v << ins[11:7];
      SH_LSR: return v >> ins[11:7];
      SH_ASR: return word_t'($signed(v) >>> ins[11:7]);
      default: return (v >> ins[11:7]) | (v << (32 - ins[11:7]));
    endcase
  endfunction

  // Executes one instruction at a time and queues every store
  task automatic runModel();
    word_t pc, ins, a, b, res, target;
    logic  pass;
    pc = '0;
    modelFlags = '0;
    for (int i = 0; i < 16; i++) begin
      modelReg[i] = '0;
    end
    for (int steps = 0; steps < 2000; steps++) begin
      ins  = imem[pc[9:2]];
      pass = condHolds(ins[31:28], modelFlags);
      if (ins[27:25] == 3'b101) begin
        target = pc + 32'd8 + {{6{ins[23]}}, ins[23:0], 2'b00};
        if (pass && target == pc) break;
        pc = pass ? target : pc + 32'd4;
      end else if (ins[27:26] == 2'b01) begin
        a = modelReg[ins[19:16]] + {20'b0, ins[11:0]};
        if (pass && ins[20]) begin
          modelReg[ins[15:12]] = modelMem[a[9:2]];
        end else if (pass) begin
          expAddrQ.push_back(a);
          expDataQ.push_back(modelReg[ins[15:12]]);
          modelMem[a[9:2]] = modelReg[ins[15:12]];
        end
        pc = pc + 32'd4;
      end else begin
        a = modelReg[ins[19:16]];
        b = operand2(ins);
        res = a - b;
        if (pass) begin
          case (ins[24:21])
            OP_ADD: modelReg[ins[15:12]] = a + b;
            OP_SUB: modelReg[ins[15:12]] = res;
            OP_AND: modelReg[ins[15:12]] = a & b;
            OP_ORR: modelReg[ins[15:12]] = a | b;
            OP_EOR: modelReg[ins[15:12]] = a ^ b;
            OP_MOV: modelReg[ins[15:12]] = b;
            default: modelFlags = {res[31], res == 0, a >= b,
                                   (a[31] != b[31]) && (res[31] != a[31])};
          endcase
        end
        pc = pc + 32'd4;
      end
    end
  endtask

  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      weSeen <= 1'b0;
    end else begin
      weSeen <= dataWe;
    end
  end

  // Memory write and queue pop away from the checking edge
  always @(negedge clk) begin
    if (dataWe) dmem[dataAddr[9:2]] = dataWdata;
    if (weSeen) begin
      storesSeen++;
      if (expAddrQ.size() > 0) begin
        void'(expAddrQ.pop_front());
        void'(expDataQ.pop_front());
      end
    end
    headValid = expAddrQ.size() > 0;
    headAddr  = headValid ? expAddrQ[0] : '0;
    headData  = headValid ? expDataQ[0] : '0;
  end

  resetQuiet: assert property (@(posedge clk) !rstN |-> !dataWe && instrAddr == '0)
    else begin
      errors++;
      $display("DUT fetched or stored while reset was held");
    end

  storeExpected: assert property (@(posedge clk) disable iff (!rstN) dataWe |-> headValid)
    else begin
      errors++;
      $display("store to %h arrived after the reference model ran out of stores",
               $sampled(dataAddr));
    end

  storeAddr: assert property (@(posedge clk) disable iff (!rstN)
    dataWe && headValid |-> dataAddr == headAddr)
    else begin
      errors++;
      $display("[ERROR] dataAddr got %h expected %h", $sampled(dataAddr), $sampled(headAddr));
    end

  storeData: assert property (@(posedge clk) disable iff (!rstN)
    dataWe && headValid |-> dataWdata == headData)
    else begin
      errors++;
      $display("[ERROR] dataWdata got %h expected %h", $sampled(dataWdata),
               $sampled(headData));
    end

  initial begin
    int waitCnt;
    errors     = 0;
    storesSeen = 0;
    headValid  = 1'b0;
    headAddr   = '0;
    headData   = '0;
    lfsr       = SEED;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i]     = '0;
      dmem[i]     = fillWord(i);
      modelMem[i] = dmem[i];
    end
    genProgram();
    runModel();
    expectedTotal = expAddrQ.size();
    headValid = expectedTotal > 0;
    headAddr  = headValid ? expAddrQ[0] : '0;
    headData  = headValid ? expDataQ[0] : '0;

    waitCnt = 0;
    while (!rstN && waitCnt < RESET_TIMEOUT) begin
      @(posedge clk);
      waitCnt++;
    end
    if (!rstN) begin
      errors++;
      $display("reset was never released");
    end

    waitCnt = 0;
    while (headValid && waitCnt < STORE_TIMEOUT) begin
      @(posedge clk);
      waitCnt++;
    end
    if (headValid) begin
      errors++;
      $display("timeout with %0d expected stores missing", expAddrQ.size());
    end

    // Spinning on the final loop must not store again
    waitCnt = 0;
    while (waitCnt < DRAIN_CYCLES) begin
      @(posedge clk);
      waitCnt++;
    end

    $display("Errors: %0d, stores seen: %0d, stores expected: %0d",
             errors, storesSeen, expectedTotal);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
rtl/armPkg.sv
rtl/regFile.sv
rtl/fetchDecode.sv
rtl/execUnit.sv
rtl/resultStage.sv
rtl/hazardUnit.sv
rtl/armPipe.sv
bench/clockGen.sv
bench/armPipeTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= armPipeTb
LOG       ?= sim.log
OBJDIR    ?= obj_dir
FILELIST  ?= vlog.f

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG) || { echo "FAIL: no result"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)
